/* sim.f */
hdl/line_bridge_pkg.sv
hdl/line_rd_if.sv
hdl/line_read_arbiter.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/line_bridge_top.sv
verif/axi_mem_model.sv
verif/tb_line_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the line bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_line_bridge \
    -Mdir obj_dir -o tb_line_bridge

./obj_dir/tb_line_bridge > sim.log
cat sim.log

grep -q "Testbench passed" sim.log

/* verif/tb_line_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_line_bridge;

    localparam int unsigned SEED = 32'h1af8_a525;
    localparam int MEM_WORDS  = 1024;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int N_RANDOM   = 30;
    localparam int TXN_BUDGET = 500;  // cycles per line transfer, stalls included
    localparam int MAX_CYCLES = (N_RANDOM + 10) * TXN_BUDGET;
    localparam int BEATS      = line_bridge_pkg::BEATS_PER_LINE;

    logic aclk = 1'b0;
    logic rst  = 1'b1;

    logic                   ic_rd_req  = 1'b0;
    line_bridge_pkg::addr_t ic_rd_addr = '0;
    logic                   ic_rd_ack;
    line_bridge_pkg::line_t ic_rd_line;
    logic                   dc_rd_req  = 1'b0;
    line_bridge_pkg::addr_t dc_rd_addr = '0;
    logic                   dc_rd_ack;
    line_bridge_pkg::line_t dc_rd_line;
    logic                   dc_wr_req  = 1'b0;
    line_bridge_pkg::addr_t dc_wr_addr = '0;
    line_bridge_pkg::line_t dc_wr_line = '0;
    logic                   dc_wr_ack;

    line_bridge_pkg::addr_t araddr;
    line_bridge_pkg::addr_t awaddr;
    line_bridge_pkg::word_t rdata;
    line_bridge_pkg::word_t wdata;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    line_bridge_pkg::word_t shadow [MEM_WORDS];  // expected memory contents
    line_bridge_pkg::line_t exp_ic_line;
    line_bridge_pkg::line_t exp_dc_line;
    string test_name   = "reset";
    logic  quiet_check = 1'b0;
    logic  tie_active  = 1'b0;
    int    errors        = 0;
    int    lines_checked = 0;
    int    cycles        = 0;

    logic                   ic_ack_q, dc_ack_q, wr_ack_q, ic_req_q, dc_req_q, wr_req_q;
    logic                   ar_wait_q, aw_wait_q, dc_first;
    line_bridge_pkg::addr_t ar_addr_q, aw_addr_q;
    logic [2:0]             w_count;

    always #4 aclk = ~aclk;

    line_bridge_top u_line_bridge_top (
        .aclk (aclk), .rst (rst),
        .ic_rd_req_i (ic_rd_req), .ic_rd_addr_i (ic_rd_addr),
        .ic_rd_ack_o (ic_rd_ack), .ic_rd_line_o (ic_rd_line),
        .dc_rd_req_i (dc_rd_req), .dc_rd_addr_i (dc_rd_addr),
        .dc_rd_ack_o (dc_rd_ack), .dc_rd_line_o (dc_rd_line),
        .dc_wr_req_i (dc_wr_req), .dc_wr_addr_i (dc_wr_addr),
        .dc_wr_line_i (dc_wr_line), .dc_wr_ack_o (dc_wr_ack),
        .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rlast_i (rlast), .rvalid_i (rvalid), .rready_o (rready),
        .awaddr_o (awaddr), .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wlast_o (wlast), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model #(.MEM_WORDS (MEM_WORDS)) u_mem (
        .aclk (aclk), .rst (rst),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rlast_o (rlast), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready)
    );

    function automatic int word_index(input line_bridge_pkg::addr_t addr);
        return int'(addr[IDX_W+1:2]);
    endfunction

    function automatic line_bridge_pkg::line_t expected_line(input line_bridge_pkg::addr_t addr);
        line_bridge_pkg::line_t line;
        for (int k = 0; k < BEATS; k++) begin
            line[k*32 +: 32] = shadow[word_index(addr) + k];
        end
        return line;
    endfunction

    function automatic line_bridge_pkg::line_t random_line();
        line_bridge_pkg::line_t line;
        for (int k = 0; k < BEATS; k++) begin
            line[k*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // full four-phase read on one of the two read ports
    task automatic read_line(input logic from_dc, input line_bridge_pkg::addr_t addr);
        @(posedge aclk);
        if (from_dc) begin
            exp_dc_line = expected_line(addr);
            dc_rd_req  <= 1'b1;
            dc_rd_addr <= addr;
            do @(posedge aclk); while (!dc_rd_ack);
            dc_rd_req <= 1'b0;
            do @(posedge aclk); while (dc_rd_ack);
        end else begin
            exp_ic_line = expected_line(addr);
            ic_rd_req  <= 1'b1;
            ic_rd_addr <= addr;
            do @(posedge aclk); while (!ic_rd_ack);
            ic_rd_req <= 1'b0;
            do @(posedge aclk); while (ic_rd_ack);
        end
    endtask

    task automatic write_line(input line_bridge_pkg::addr_t addr,
                              input line_bridge_pkg::line_t line);
        @(posedge aclk);
        for (int k = 0; k < BEATS; k++) begin
            shadow[word_index(addr) + k] = line[k*32 +: 32];
        end
        dc_wr_req  <= 1'b1;
        dc_wr_addr <= addr;
        dc_wr_line <= line;
        do @(posedge aclk); while (!dc_wr_ack);
        dc_wr_req <= 1'b0;
        do @(posedge aclk); while (dc_wr_ack);
    endtask

    always @(posedge aclk) begin
        if (rst) begin
            ic_ack_q  <= 1'b0;
            dc_ack_q  <= 1'b0;
            wr_ack_q  <= 1'b0;
            ic_req_q  <= 1'b0;
            dc_req_q  <= 1'b0;
            wr_req_q  <= 1'b0;
            ar_wait_q <= 1'b0;
            aw_wait_q <= 1'b0;
            dc_first  <= 1'b0;
            w_count   <= '0;
        end else begin
            if (quiet_check) begin
                assert (!(arvalid | awvalid | wvalid | rready | bready |
                          ic_rd_ack | dc_rd_ack | dc_wr_ack)) else begin
                    errors++;
                    $display("FAIL %s quiet expected %b actual %b", test_name, 8'b0,
                             {arvalid, awvalid, wvalid, rready, bready,
                              ic_rd_ack, dc_rd_ack, dc_wr_ack});
                end
            end
            if (ic_rd_ack && !ic_ack_q) begin
                lines_checked++;
                assert (ic_rd_line == exp_ic_line) else begin
                    errors++;
                    $display("FAIL %s ic_line expected %h actual %h",
                             test_name, exp_ic_line, ic_rd_line);
                end
                if (tie_active) begin
                    assert (dc_first) else begin
                        errors++;
                        $display("%s: icache ack rose before the dcache ack", test_name);
                    end
                end
            end
            if (dc_rd_ack && !dc_ack_q) begin
                lines_checked++;
                assert (dc_rd_line == exp_dc_line) else begin
                    errors++;
                    $display("FAIL %s dc_line expected %h actual %h",
                             test_name, exp_dc_line, dc_rd_line);
                end
            end
            dc_first <= tie_active && (dc_first || dc_rd_ack);
            // ack may only fall once req is gone
            assert (!(ic_ack_q && ic_req_q) || ic_rd_ack) else begin
                errors++;
                $display("FAIL %s ic_ack_hold expected 1 actual %b", test_name, ic_rd_ack);
            end
            assert (!(dc_ack_q && dc_req_q) || dc_rd_ack) else begin
                errors++;
                $display("FAIL %s dc_ack_hold expected 1 actual %b", test_name, dc_rd_ack);
            end
            assert (!(wr_ack_q && wr_req_q) || dc_wr_ack) else begin
                errors++;
                $display("FAIL %s wr_ack_hold expected 1 actual %b", test_name, dc_wr_ack);
            end
            assert (!ar_wait_q || (arvalid && araddr == ar_addr_q)) else begin
                errors++;
                $display("FAIL %s ar_stable expected 1/%h actual %b/%h",
                         test_name, ar_addr_q, arvalid, araddr);
            end
            assert (!aw_wait_q || (awvalid && awaddr == aw_addr_q)) else begin
                errors++;
                $display("FAIL %s aw_stable expected 1/%h actual %b/%h",
                         test_name, aw_addr_q, awvalid, awaddr);
            end
            if (wvalid && wready) begin
                assert (wlast == (w_count == 3'd7)) else begin
                    errors++;
                    $display("FAIL %s wlast beat %0d expected %b actual %b",
                             test_name, w_count, (w_count == 3'd7), wlast);
                end
                w_count <= w_count + 3'd1;
            end
            ic_ack_q  <= ic_rd_ack;
            dc_ack_q  <= dc_rd_ack;
            wr_ack_q  <= dc_wr_ack;
            ic_req_q  <= ic_rd_req;
            dc_req_q  <= dc_rd_req;
            wr_req_q  <= dc_wr_req;
            ar_wait_q <= arvalid && !arready;
            aw_wait_q <= awvalid && !awready;
            ar_addr_q <= araddr;
            aw_addr_q <= awaddr;
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no end of run within %0d cycles", MAX_CYCLES);
            $display("lines checked %0d, errors %0d", lines_checked, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        line_bridge_pkg::addr_t rnd_addr;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = line_bridge_pkg::word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        repeat (8) @(posedge aclk);
        rst         <= 1'b0;
        quiet_check <= 1'b1;
        repeat (8) @(posedge aclk);
        quiet_check <= 1'b0;

        test_name = "ic_read";
        read_line(1'b0, 32'h0000_0140);

        test_name = "write_readback";
        write_line(32'h0000_0260, random_line());
        read_line(1'b1, 32'h0000_0260);

        test_name = "tie";
        tie_active <= 1'b1;
        fork
            read_line(1'b1, 32'h0000_03a0);
            read_line(1'b0, 32'h0000_0120);
        join
        tie_active <= 1'b0;

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd_addr = line_bridge_pkg::addr_t'($urandom_range(0, 31)) << 5;
            case ($urandom_range(0, 2))
                0: read_line(1'b0, rnd_addr);
                1: read_line(1'b1, rnd_addr);
                default: write_line(rnd_addr, random_line());
            endcase
        end

        repeat (4) @(posedge aclk);
        $display("lines checked %0d, errors %0d", lines_checked, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI slave memory, 8 beat INCR bursts, random stalls
module axi_mem_model #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire line_bridge_pkg::addr_t araddr_i,
    input  wire                         arvalid_i,
    output logic                        arready_o,
    output line_bridge_pkg::word_t      rdata_o,
    output logic                        rlast_o,
    output logic                        rvalid_o,
    input  wire                         rready_i,
    input  wire line_bridge_pkg::addr_t awaddr_i,
    input  wire                         awvalid_i,
    output logic                        awready_o,
    input  wire line_bridge_pkg::word_t wdata_i,
    input  wire                         wvalid_i,
    output logic                        wready_o,
    output logic                        bvalid_o,
    input  wire                         bready_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    line_bridge_pkg::word_t mem [MEM_WORDS];
    logic                   rd_busy;
    line_bridge_pkg::addr_t rd_addr;
    logic [2:0]             rd_beat;
    logic                   wr_data;
    logic                   wr_resp;
    line_bridge_pkg::addr_t wr_addr;
    logic [2:0]             wr_beat;

    function automatic int word_index(input line_bridge_pkg::addr_t addr);
        return int'(addr[IDX_W+1:2]);
    endfunction

    initial begin
        arready_o = 1'b0;
        rdata_o   = '0;
        rlast_o   = 1'b0;
        rvalid_o  = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = line_bridge_pkg::word_t'(i * 4) ^ 32'h5a5a_0000;
        end
    end

    // read side
    always @(posedge aclk) begin
        if (rst) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            rd_busy   <= 1'b0;
            rd_beat   <= '0;
        end else if (!rd_busy) begin
            if (arvalid_i && arready_o) begin
                rd_busy   <= 1'b1;
                rd_addr   <= araddr_i;
                rd_beat   <= '0;
                arready_o <= 1'b0;
            end else begin
                arready_o <= 1'($urandom_range(0, 1));
            end
        end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
            rd_beat  <= rd_beat + 3'd1;
            if (rlast_o) begin
                rd_busy <= 1'b0;
            end
        end else if (!rvalid_o && $urandom_range(0, 3) != 0) begin
            rvalid_o <= 1'b1;  // held until taken
            rdata_o  <= mem[word_index(rd_addr) + int'(rd_beat)];
            rlast_o  <= (rd_beat == 3'd7);
        end
    end

    // write side
    always @(posedge aclk) begin
        if (rst) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            wr_data   <= 1'b0;
            wr_resp   <= 1'b0;
            wr_beat   <= '0;
        end else if (!wr_data && !wr_resp) begin
            if (awvalid_i && awready_o) begin
                wr_data   <= 1'b1;
                wr_addr   <= awaddr_i;
                wr_beat   <= '0;
                awready_o <= 1'b0;
            end else begin
                awready_o <= 1'($urandom_range(0, 1));
            end
        end else if (wr_data) begin
            if (wvalid_i && wready_o) begin
                mem[word_index(wr_addr) + int'(wr_beat)] <= wdata_i;
                wr_beat  <= wr_beat + 3'd1;
                wready_o <= 1'b0;
                if (wr_beat == 3'd7) begin
                    wr_data <= 1'b0;
                    wr_resp <= 1'b1;
                end
            end else begin
                wready_o <= 1'($urandom_range(0, 1));
            end
        end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
            wr_resp  <= 1'b0;
        end else if (!bvalid_o) begin
            bvalid_o <= ($urandom_range(0, 3) == 0);
        end
    end

endmodule

`default_nettype wire

/* hdl/line_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module line_bridge_top (
    input  wire                    aclk,
    input  wire                    rst,

    // icache line read
    input  wire                    ic_rd_req_i,
    input  wire line_bridge_pkg::addr_t ic_rd_addr_i,
    output logic                   ic_rd_ack_o,
    output line_bridge_pkg::line_t ic_rd_line_o,

    // dcache line read
    input  wire                    dc_rd_req_i,
    input  wire line_bridge_pkg::addr_t dc_rd_addr_i,
    output logic                   dc_rd_ack_o,
    output line_bridge_pkg::line_t dc_rd_line_o,

    // dcache write-back
    input  wire                    dc_wr_req_i,
    input  wire line_bridge_pkg::addr_t dc_wr_addr_i,
    input  wire line_bridge_pkg::line_t dc_wr_line_i,
    output logic                   dc_wr_ack_o,

    // AXI read
    output line_bridge_pkg::addr_t araddr_o,
    output logic                   arvalid_o,
    input  wire                    arready_i,
    input  wire line_bridge_pkg::word_t rdata_i,
    input  wire                    rlast_i,
    input  wire                    rvalid_i,
    output logic                   rready_o,

    // AXI write
    output line_bridge_pkg::addr_t awaddr_o,
    output logic                   awvalid_o,
    input  wire                    awready_i,
    output line_bridge_pkg::word_t wdata_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  wire                    wready_i,
    input  wire                    bvalid_i,
    output logic                   bready_o
);

    line_rd_if rd_bus ();  // granted read, arbiter to engine

    line_read_arbiter u_read_arbiter (
        .aclk      (aclk),
        .rst       (rst),
        .ic_req_i  (ic_rd_req_i),
        .ic_addr_i (ic_rd_addr_i),
        .ic_ack_o  (ic_rd_ack_o),
        .ic_line_o (ic_rd_line_o),
        .dc_req_i  (dc_rd_req_i),
        .dc_addr_i (dc_rd_addr_i),
        .dc_ack_o  (dc_rd_ack_o),
        .dc_line_o (dc_rd_line_o),
        .rd        (rd_bus.arbiter)
    );

    axi_read_engine u_read_engine (
        .aclk      (aclk),
        .rst       (rst),
        .rd        (rd_bus.engine),
        .araddr_o  (araddr_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rlast_i   (rlast_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

    // write path runs beside the reads
    axi_write_engine u_write_engine (
        .aclk      (aclk),
        .rst       (rst),
        .req_i     (dc_wr_req_i),
        .addr_i    (dc_wr_addr_i),
        .line_i    (dc_wr_line_i),
        .ack_o     (dc_wr_ack_o),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wlast_o   (wlast_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

`default_nettype wire

/* hdl/axi_write_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
    input  wire                    aclk,
    input  wire                    rst,

    // data cache write-back client
    input  wire                    req_i,
    input  wire line_bridge_pkg::addr_t addr_i,
    input  wire line_bridge_pkg::line_t line_i,
    output logic                   ack_o,

    // AXI AW channel
    output line_bridge_pkg::addr_t awaddr_o,
    output logic                   awvalid_o,
    input  wire                    awready_i,

    // AXI W channel
    output line_bridge_pkg::word_t wdata_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  wire                    wready_i,

    // AXI B channel
    input  wire                    bvalid_i,
    output logic                   bready_o
);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_e;

    wr_state_e                                state_q;
    logic [line_bridge_pkg::BEAT_IDX_W-1:0]   beat_q;
    line_bridge_pkg::addr_t                   addr_q;
    line_bridge_pkg::line_t                   line_q;
    logic                                     last_beat;

    assign last_beat = (beat_q == (line_bridge_pkg::BEATS_PER_LINE - 1));

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    beat_q <= '0;
                    if (req_i) begin
                        state_q <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready_i) begin
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        state_q <= WR_DONE;
                    end
                end
                WR_DONE: begin
                    if (!req_i) begin
                        state_q <= WR_IDLE;
                    end
                end
                default: begin
                    state_q <= WR_IDLE;
                end
            endcase
        end
    end

    // capture the victim line when the request is taken
    always_ff @(posedge aclk) begin
        if (state_q == WR_IDLE && req_i) begin
            addr_q <= addr_i;
            line_q <= line_i;
        end
    end

    assign awaddr_o  = {addr_q[line_bridge_pkg::ADDR_W-1:line_bridge_pkg::LINE_OFFSET_W],
                        {line_bridge_pkg::LINE_OFFSET_W{1'b0}}};
    assign awvalid_o = (state_q == WR_ADDR);

    assign wdata_o  = line_q[beat_q * line_bridge_pkg::WORD_W +: line_bridge_pkg::WORD_W];
    assign wvalid_o = (state_q == WR_DATA);
    assign wlast_o  = (state_q == WR_DATA) && last_beat;  // beat 8 only

    assign bready_o = (state_q == WR_RESP);
    assign ack_o    = (state_q == WR_DONE);

endmodule

`default_nettype wire

/* hdl/axi_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
    input  wire                    aclk,
    input  wire                    rst,

    line_rd_if.engine              rd,

    // AXI AR channel
    output line_bridge_pkg::addr_t araddr_o,
    output logic                   arvalid_o,
    input  wire                    arready_i,

    // AXI R channel
    input  wire line_bridge_pkg::word_t rdata_i,
    input  wire                    rlast_i,
    input  wire                    rvalid_i,
    output logic                   rready_o
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_DONE
    } rd_state_e;

    rd_state_e                                state_q;
    logic [line_bridge_pkg::BEAT_IDX_W-1:0]   beat_q;
    line_bridge_pkg::line_t                   line_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= RD_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    beat_q <= '0;
                    if (rd.req) begin
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (rlast_i) begin
                            state_q <= RD_DONE;
                        end
                    end
                end
                RD_DONE: begin
                    if (!rd.req) begin
                        state_q <= RD_IDLE;  // ack drops next cycle
                    end
                end
                default: begin
                    state_q <= RD_IDLE;
                end
            endcase
        end
    end

    // beats land in word order
    always_ff @(posedge aclk) begin
        if (state_q == RD_DATA && rvalid_i) begin
            line_q[beat_q * line_bridge_pkg::WORD_W +: line_bridge_pkg::WORD_W] <= rdata_i;
        end
    end

    // line aligned burst start
    assign araddr_o  = {rd.addr[line_bridge_pkg::ADDR_W-1:line_bridge_pkg::LINE_OFFSET_W],
                        {line_bridge_pkg::LINE_OFFSET_W{1'b0}}};
    assign arvalid_o = (state_q == RD_ADDR);
    assign rready_o  = (state_q == RD_DATA);

    assign rd.ack  = (state_q == RD_DONE);
    assign rd.line = line_q;

endmodule

`default_nettype wire

/* hdl/line_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_read_arbiter (
    input  wire                    aclk,
    input  wire                    rst,

    // instruction cache read client
    input  wire                    ic_req_i,
    input  wire line_bridge_pkg::addr_t ic_addr_i,
    output logic                   ic_ack_o,
    output line_bridge_pkg::line_t ic_line_o,

    // data cache read client
    input  wire                    dc_req_i,
    input  wire line_bridge_pkg::addr_t dc_addr_i,
    output logic                   dc_ack_o,
    output line_bridge_pkg::line_t dc_line_o,

    line_rd_if.arbiter             rd
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT,
        ARB_DRAIN
    } arb_state_e;

    arb_state_e             state_q;
    logic                   owner_dc_q;  // 1 = data cache owns the read
    line_bridge_pkg::addr_t addr_q;
    logic                   owner_req;

    assign owner_req = owner_dc_q ? dc_req_i : ic_req_i;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            owner_dc_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // dcache wins a tie
                    if (dc_req_i) begin
                        owner_dc_q <= 1'b1;
                        state_q    <= ARB_GRANT;
                    end else if (ic_req_i) begin
                        owner_dc_q <= 1'b0;
                        state_q    <= ARB_GRANT;
                    end
                end
                ARB_GRANT: begin
                    if (!owner_req) begin
                        state_q <= ARB_DRAIN;  // client saw ack and let go
                    end
                end
                ARB_DRAIN: begin
                    if (!rd.ack) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    // address of the winner, frozen once granted
    always_ff @(posedge aclk) begin
        if (state_q == ARB_IDLE) begin
            addr_q <= dc_req_i ? dc_addr_i : ic_addr_i;
        end
    end

    assign rd.req  = (state_q == ARB_GRANT);
    assign rd.addr = addr_q;

    // engine ack passes straight through to the owner
    assign dc_ack_o = owner_dc_q && rd.ack;
    assign ic_ack_o = !owner_dc_q && rd.ack;

    assign dc_line_o = owner_dc_q ? rd.line : '0;
    assign ic_line_o = owner_dc_q ? '0 : rd.line;

endmodule

`default_nettype wire

/* hdl/line_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one granted line read, four-phase req/ack
interface line_rd_if;

    logic                   req;
    line_bridge_pkg::addr_t addr;
    logic                   ack;
    line_bridge_pkg::line_t line;  // valid while ack high

    modport arbiter (
        output req,
        output addr,
        input  ack,
        input  line
    );

    modport engine (
        input  req,
        input  addr,
        output ack,
        output line
    );

endinterface

`default_nettype wire

/* hdl/line_bridge_pkg.sv */
`default_nettype none

package line_bridge_pkg;

    // bus and line geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BEATS_PER_LINE = 8;
    localparam int BEAT_IDX_W     = 3;  // log2 of beats per line
    localparam int LINE_W         = WORD_W * BEATS_PER_LINE;
    localparam int LINE_OFFSET_W  = 5;  // 32-byte lines

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // one AXI beat
    typedef logic [WORD_W-1:0] word_t;

    // word k sits at bits 32k upward, address base + 4k
    typedef logic [LINE_W-1:0] line_t;

endpackage

`default_nettype wire
